// File: build.f
logic/noc_pkg.sv
logic/flit_pkg.sv
logic/input_buffer.sv
logic/switch_control.sv
logic/hermes_router.sv
logic/manycore_mesh_top.sv
testbench/manycore_mesh_assert.sv
testbench/manycore_mesh_tb.sv

// File: logic/flit_pkg.sv
package flit_pkg;

  localparam int FLIT_WIDTH = 32;

  // header flit layout
  // [7:0] payload length, [8] dest x, [12] dest y, [16 +: 8] source node
  localparam int LEN_LSB = 0;
  localparam int LEN_WIDTH = 8;

  localparam int DEST_X_LSB = 8;
  localparam int DEST_Y_LSB = 12;

  // source node index, not looked at by the routers
  localparam int SRC_LSB = 16;

  // switch control walk over one header
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ROUTE   = 2'd1,
    GRANT   = 2'd2,
    FORWARD = 2'd3
  } switch_state_e;

endpackage : flit_pkg

// File: logic/hermes_router.sv
`timescale 1ns/100ps

module hermes_router (
  input  logic                                                     clock,
  input  logic                                                     rst_n_i,
  input  logic [noc_pkg::COORD_WIDTH-1:0]                          my_x_i,
  input  logic [noc_pkg::COORD_WIDTH-1:0]                          my_y_i,
  input  logic [noc_pkg::PORT_COUNT-1:0]                           rx_i,
  input  logic [noc_pkg::PORT_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] data_i,
  input  logic [noc_pkg::PORT_COUNT-1:0]                           credit_i,
  output logic [noc_pkg::PORT_COUNT-1:0]                           credit_o,
  output logic [noc_pkg::PORT_COUNT-1:0]                           tx_o,
  output logic [noc_pkg::PORT_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] data_o
);

  logic [noc_pkg::PORT_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] head;
  logic [noc_pkg::PORT_COUNT-1:0]                           empty;
  logic [noc_pkg::PORT_COUNT-1:0]                           read;
  noc_pkg::router_port_e [noc_pkg::PORT_COUNT-1:0]          select;

  // one fifo per input port
  genvar p;
  generate
    for (p = 0; p < noc_pkg::PORT_COUNT; p++) begin : in_port
      input_buffer input_buffer_inst (
        .clock    (clock),
        .rst_n_i  (rst_n_i),
        .rx_i     (rx_i[p]),
        .data_i   (data_i[p]),
        .read_i   (read[p]),
        .credit_o (credit_o[p]),
        .head_o   (head[p]),
        .empty_o  (empty[p])
      );
    end
  endgenerate

  switch_control switch_control_inst (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .my_x_i   (my_x_i),
    .my_y_i   (my_y_i),
    .head_i   (head),
    .empty_i  (empty),
    .credit_i (credit_i),
    .read_o   (read),
    .tx_o     (tx_o),
    .select_o (select)
  );

  // crossbar
  // data is only meaningful while tx is high
  always_comb begin
    for (int o = 0; o < noc_pkg::PORT_COUNT; o++) begin
      data_o[o] = head[select[o]];
    end
  end

endmodule : hermes_router

// File: logic/input_buffer.sv
`timescale 1ns/100ps

module input_buffer (
  input  logic                            clock,
  input  logic                            rst_n_i,
  input  logic                            rx_i,
  input  logic [flit_pkg::FLIT_WIDTH-1:0] data_i,
  input  logic                            read_i,
  output logic                            credit_o,
  output logic [flit_pkg::FLIT_WIDTH-1:0] head_o,
  output logic                            empty_o
);

  logic [flit_pkg::FLIT_WIDTH-1:0] mem [noc_pkg::BUFFER_DEPTH];

  logic [$clog2(noc_pkg::BUFFER_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(noc_pkg::BUFFER_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(noc_pkg::BUFFER_DEPTH):0]   count_q;
  logic                                     wr_en;
  logic                                     rd_en;

  // credit stays high while a slot is free
  assign credit_o = (count_q != noc_pkg::BUFFER_DEPTH);
  assign empty_o  = (count_q == '0);
  assign head_o   = mem[rd_ptr_q];

  assign wr_en = rx_i && credit_o;
  assign rd_en = read_i && !empty_o;

  // flit storage
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == noc_pkg::BUFFER_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::BUFFER_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // fill level, unchanged on push and pop together
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : input_buffer

// File: logic/manycore_mesh_top.sv
`timescale 1ns/100ps

module manycore_mesh_top (
  input  logic                                                     clock,
  input  logic                                                     rst_n_i,
  input  logic [noc_pkg::NODE_COUNT-1:0]                           in_tx_i,
  input  logic [noc_pkg::NODE_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] in_data_i,
  input  logic [noc_pkg::NODE_COUNT-1:0]                           out_credit_i,
  output logic [noc_pkg::NODE_COUNT-1:0]                           in_credit_o,
  output logic [noc_pkg::NODE_COUNT-1:0]                           out_tx_o,
  output logic [noc_pkg::NODE_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] out_data_o
);

  // router side wires, indexed [x][y][port]
  wire [noc_pkg::NOC_DIM_X-1:0][noc_pkg::NOC_DIM_Y-1:0][noc_pkg::PORT_COUNT-1:0] rx;
  wire [noc_pkg::NOC_DIM_X-1:0][noc_pkg::NOC_DIM_Y-1:0][noc_pkg::PORT_COUNT-1:0] tx;
  wire [noc_pkg::NOC_DIM_X-1:0][noc_pkg::NOC_DIM_Y-1:0][noc_pkg::PORT_COUNT-1:0] credit_in;
  wire [noc_pkg::NOC_DIM_X-1:0][noc_pkg::NOC_DIM_Y-1:0][noc_pkg::PORT_COUNT-1:0] credit_out;
  wire [noc_pkg::NOC_DIM_X-1:0][noc_pkg::NOC_DIM_Y-1:0][noc_pkg::PORT_COUNT-1:0]
       [flit_pkg::FLIT_WIDTH-1:0] data_in;
  wire [noc_pkg::NOC_DIM_X-1:0][noc_pkg::NOC_DIM_Y-1:0][noc_pkg::PORT_COUNT-1:0]
       [flit_pkg::FLIT_WIDTH-1:0] data_out;

  genvar x, y;
  generate
    for (x = 0; x < noc_pkg::NOC_DIM_X; x++) begin : router_x
      for (y = 0; y < noc_pkg::NOC_DIM_Y; y++) begin : router_y

        hermes_router hermes_router_inst (
          .clock    (clock),
          .rst_n_i  (rst_n_i),
          .my_x_i   ((noc_pkg::COORD_WIDTH)'(x)),
          .my_y_i   ((noc_pkg::COORD_WIDTH)'(y)),
          .rx_i     (rx[x][y]),
          .data_i   (data_in[x][y]),
          .credit_i (credit_in[x][y]),
          .credit_o (credit_out[x][y]),
          .tx_o     (tx[x][y]),
          .data_o   (data_out[x][y])
        );

        // local port straight to the top level pe side
        assign rx[x][y][noc_pkg::LOCAL]        = in_tx_i[x + y * noc_pkg::NOC_DIM_X];
        assign data_in[x][y][noc_pkg::LOCAL]   = in_data_i[x + y * noc_pkg::NOC_DIM_X];
        assign credit_in[x][y][noc_pkg::LOCAL] = out_credit_i[x + y * noc_pkg::NOC_DIM_X];
        assign in_credit_o[x + y * noc_pkg::NOC_DIM_X] = credit_out[x][y][noc_pkg::LOCAL];
        assign out_tx_o[x + y * noc_pkg::NOC_DIM_X]    = tx[x][y][noc_pkg::LOCAL];
        assign out_data_o[x + y * noc_pkg::NOC_DIM_X]  = data_out[x][y][noc_pkg::LOCAL];

        // west side, grounded on the border
        if (x == 0) begin : west_border
          assign rx[x][y][noc_pkg::WEST]        = 1'b0;
          assign data_in[x][y][noc_pkg::WEST]   = '0;
          assign credit_in[x][y][noc_pkg::WEST] = 1'b0;
        end else begin : west_link
          assign rx[x][y][noc_pkg::WEST]        = tx[x-1][y][noc_pkg::EAST];
          assign data_in[x][y][noc_pkg::WEST]   = data_out[x-1][y][noc_pkg::EAST];
          assign credit_in[x][y][noc_pkg::WEST] = credit_out[x-1][y][noc_pkg::EAST];
        end

        if (x == noc_pkg::NOC_DIM_X - 1) begin : east_border
          assign rx[x][y][noc_pkg::EAST]        = 1'b0;
          assign data_in[x][y][noc_pkg::EAST]   = '0;
          assign credit_in[x][y][noc_pkg::EAST] = 1'b0;
        end else begin : east_link
          assign rx[x][y][noc_pkg::EAST]        = tx[x+1][y][noc_pkg::WEST];
          assign data_in[x][y][noc_pkg::EAST]   = data_out[x+1][y][noc_pkg::WEST];
          assign credit_in[x][y][noc_pkg::EAST] = credit_out[x+1][y][noc_pkg::WEST];
        end

        // south is the row below
        if (y == 0) begin : south_border
          assign rx[x][y][noc_pkg::SOUTH]        = 1'b0;
          assign data_in[x][y][noc_pkg::SOUTH]   = '0;
          assign credit_in[x][y][noc_pkg::SOUTH] = 1'b0;
        end else begin : south_link
          assign rx[x][y][noc_pkg::SOUTH]        = tx[x][y-1][noc_pkg::NORTH];
          assign data_in[x][y][noc_pkg::SOUTH]   = data_out[x][y-1][noc_pkg::NORTH];
          assign credit_in[x][y][noc_pkg::SOUTH] = credit_out[x][y-1][noc_pkg::NORTH];
        end

        if (y == noc_pkg::NOC_DIM_Y - 1) begin : north_border
          assign rx[x][y][noc_pkg::NORTH]        = 1'b0;
          assign data_in[x][y][noc_pkg::NORTH]   = '0;
          assign credit_in[x][y][noc_pkg::NORTH] = 1'b0;
        end else begin : north_link
          assign rx[x][y][noc_pkg::NORTH]        = tx[x][y+1][noc_pkg::SOUTH];
          assign data_in[x][y][noc_pkg::NORTH]   = data_out[x][y+1][noc_pkg::SOUTH];
          assign credit_in[x][y][noc_pkg::NORTH] = credit_out[x][y+1][noc_pkg::SOUTH];
        end

      end
    end
  endgenerate

endmodule : manycore_mesh_top

// File: logic/noc_pkg.sv
package noc_pkg;

  // mesh size in routers
  localparam int NOC_DIM_X = 2;
  localparam int NOC_DIM_Y = 2;

  // node index is x + y * NOC_DIM_X
  localparam int NODE_COUNT = NOC_DIM_X * NOC_DIM_Y;

  // bits per header coordinate
  localparam int COORD_WIDTH = 1;

  // flits held by each router input fifo
  localparam int BUFFER_DEPTH = 4;

  // four neighbours plus the local pe
  localparam int PORT_COUNT = 5;

  // port numbering, shared by router, switch and mesh wiring
  typedef enum logic [2:0] {
    EAST  = 3'd0,
    WEST  = 3'd1,
    NORTH = 3'd2,
    SOUTH = 3'd3,
    LOCAL = 3'd4
  } router_port_e;

endpackage : noc_pkg

// File: logic/switch_control.sv
`timescale 1ns/100ps

module switch_control (
  input  logic                                                     clock,
  input  logic                                                     rst_n_i,
  input  logic [noc_pkg::COORD_WIDTH-1:0]                          my_x_i,
  input  logic [noc_pkg::COORD_WIDTH-1:0]                          my_y_i,
  input  logic [noc_pkg::PORT_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] head_i,
  input  logic [noc_pkg::PORT_COUNT-1:0]                           empty_i,
  input  logic [noc_pkg::PORT_COUNT-1:0]                           credit_i,
  output logic [noc_pkg::PORT_COUNT-1:0]                           read_o,
  output logic [noc_pkg::PORT_COUNT-1:0]                           tx_o,
  output noc_pkg::router_port_e [noc_pkg::PORT_COUNT-1:0]          select_o
);

  flit_pkg::switch_state_e state_q;

  noc_pkg::router_port_e sel_q;
  noc_pkg::router_port_e last_q;
  noc_pkg::router_port_e route_q;
  noc_pkg::router_port_e next_sel;
  noc_pkg::router_port_e xy_port;
  logic                  found;

  logic [noc_pkg::COORD_WIDTH-1:0] dest_x;
  logic [noc_pkg::COORD_WIDTH-1:0] dest_y;

  // per output connection state
  logic [noc_pkg::PORT_COUNT-1:0]                  out_busy_q;
  noc_pkg::router_port_e [noc_pkg::PORT_COUNT-1:0] owner_q;
  logic [flit_pkg::LEN_WIDTH:0]                    count_q [noc_pkg::PORT_COUNT];
  logic [noc_pkg::PORT_COUNT-1:0]                  in_busy;

  assign select_o = owner_q;

  // inputs already connected to some output
  always_comb begin
    in_busy = '0;
    for (int o = 0; o < noc_pkg::PORT_COUNT; o++) begin
      if (out_busy_q[o]) begin
        in_busy[owner_q[o]] = 1'b1;
      end
    end
  end

  // round robin, starting after the last input looked at
  always_comb begin : rr_scan
    int idx;
    idx      = 0;
    found    = 1'b0;
    next_sel = last_q;
    for (int k = 1; k <= noc_pkg::PORT_COUNT; k++) begin
      idx = (int'(last_q) + k) % noc_pkg::PORT_COUNT;
      if (!found && !empty_i[idx] && !in_busy[idx]) begin
        found    = 1'b1;
        next_sel = noc_pkg::router_port_e'(idx);
      end
    end
  end

  // xy routing, x first
  assign dest_x = head_i[sel_q][flit_pkg::DEST_X_LSB +: noc_pkg::COORD_WIDTH];
  assign dest_y = head_i[sel_q][flit_pkg::DEST_Y_LSB +: noc_pkg::COORD_WIDTH];

  always_comb begin
    if (dest_x > my_x_i) begin
      xy_port = noc_pkg::EAST;
    end else if (dest_x < my_x_i) begin
      xy_port = noc_pkg::WEST;
    end else if (dest_y > my_y_i) begin
      xy_port = noc_pkg::NORTH;
    end else if (dest_y < my_y_i) begin
      xy_port = noc_pkg::SOUTH;
    end else begin
      xy_port = noc_pkg::LOCAL;
    end
  end

  // one flit per live connection while downstream has room
  always_comb begin
    read_o = '0;
    for (int o = 0; o < noc_pkg::PORT_COUNT; o++) begin
      tx_o[o] = out_busy_q[o] && !empty_i[owner_q[o]] && credit_i[o];
      if (tx_o[o]) begin
        read_o[owner_q[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q <= flit_pkg::IDLE;
      sel_q   <= noc_pkg::LOCAL;
      last_q  <= noc_pkg::LOCAL;
      route_q <= noc_pkg::LOCAL;
    end else begin
      case (state_q)
        flit_pkg::IDLE: begin
          if (found) begin
            sel_q   <= next_sel;
            state_q <= flit_pkg::ROUTE;
          end
        end
        flit_pkg::ROUTE: begin
          route_q <= xy_port;
          state_q <= flit_pkg::GRANT;
        end
        flit_pkg::GRANT: begin
          if (out_busy_q[route_q]) begin
            // output taken, retry later and let the others in first
            last_q  <= sel_q;
            state_q <= flit_pkg::IDLE;
          end else begin
            state_q <= flit_pkg::FORWARD;
          end
        end
        default: begin
          // connection is live, next scan starts after the served input
          last_q  <= sel_q;
          state_q <= flit_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      out_busy_q <= '0;
      for (int o = 0; o < noc_pkg::PORT_COUNT; o++) begin
        owner_q[o] <= noc_pkg::LOCAL;
        count_q[o] <= '0;
      end
    end else begin
      for (int o = 0; o < noc_pkg::PORT_COUNT; o++) begin
        if (tx_o[o]) begin
          count_q[o] <= count_q[o] - 1'b1;
          if (count_q[o] == 1) begin
            out_busy_q[o] <= 1'b0;
          end
        end
      end
      // header plus payload flits
      if (state_q == flit_pkg::GRANT && !out_busy_q[route_q]) begin
        out_busy_q[route_q] <= 1'b1;
        owner_q[route_q]    <= sel_q;
        count_q[route_q]    <= {1'b0, head_i[sel_q][flit_pkg::LEN_LSB +: flit_pkg::LEN_WIDTH]}
                               + 1'b1;
      end
    end
  end

endmodule : switch_control

// File: testbench/manycore_mesh_assert.sv
`timescale 1ns/100ps

module manycore_mesh_assert (
  input logic                           clock,
  input logic                           rst_n_i,
  input logic [noc_pkg::NODE_COUNT-1:0] out_credit_i,
  input logic [noc_pkg::NODE_COUNT-1:0] out_tx_o,
  input logic [noc_pkg::NODE_COUNT-1:0] in_credit_o
);

  // number of assertion failures so far
  int failures;

  // a local flit only leaves when the pe can take it
  property no_tx_without_credit;
    @(posedge clock) disable iff (!rst_n_i) (out_tx_o & ~out_credit_i) == '0;
  endproperty

  property tx_known;
    @(posedge clock) disable iff (!rst_n_i) !$isunknown(out_tx_o);
  endproperty

  // all fifos empty right after reset
  property credit_high_after_reset;
    @(posedge clock) $rose(rst_n_i) |-> (in_credit_o == '1);
  endproperty

  assert property (no_tx_without_credit)
    else begin
      $error("out_tx_o high while out_credit_i low");
      failures++;
    end

  assert property (tx_known)
    else begin
      $error("out_tx_o unknown after reset");
      failures++;
    end

  assert property (credit_high_after_reset)
    else begin
      $error("in_credit_o low after reset");
      failures++;
    end

endmodule : manycore_mesh_assert

bind manycore_mesh_top manycore_mesh_assert manycore_mesh_assert_inst (.*);

// File: testbench/manycore_mesh_tb.sv
`timescale 1ns/100ps

module manycore_mesh_tb;

  // payload lengths of the directed tests
  localparam int ALL_PAIRS_LEN  = 3;
  localparam int CONTENTION_LEN = 16;
  localparam int BP_LEN         = 20;
  localparam int CROSS_LEN      = 6;
  localparam int BP_WAIT        = 200;

  localparam int TOTAL_FLITS = noc_pkg::NODE_COUNT * noc_pkg::NODE_COUNT * (ALL_PAIRS_LEN + 1)
                               + 2 * (CONTENTION_LEN + 1) + (BP_LEN + 1)
                               + noc_pkg::NODE_COUNT * (CROSS_LEN + 1);
  localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 40 + 500;

  logic                                                     clock;
  logic                                                     rst_n_i;
  logic [noc_pkg::NODE_COUNT-1:0]                           in_tx_i;
  logic [noc_pkg::NODE_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] in_data_i;
  logic [noc_pkg::NODE_COUNT-1:0]                           out_credit_i;
  logic [noc_pkg::NODE_COUNT-1:0]                           in_credit_o;
  logic [noc_pkg::NODE_COUNT-1:0]                           out_tx_o;
  logic [noc_pkg::NODE_COUNT-1:0][flit_pkg::FLIT_WIDTH-1:0] out_data_o;

  // flits seen at each local out port and flits sent per source/destination pair
  logic [flit_pkg::FLIT_WIDTH-1:0] rx_q [noc_pkg::NODE_COUNT][$];
  logic [flit_pkg::FLIT_WIDTH-1:0] sent_q [noc_pkg::NODE_COUNT * noc_pkg::NODE_COUNT][$];
  int                              rx_count;

  manycore_mesh_top manycore_mesh_top_inst (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .in_tx_i      (in_tx_i),
    .in_data_i    (in_data_i),
    .out_credit_i (out_credit_i),
    .in_credit_o  (in_credit_o),
    .out_tx_o     (out_tx_o),
    .out_data_o   (out_data_o)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // header carries length, destination x and y and the source node
  function automatic logic [flit_pkg::FLIT_WIDTH-1:0] make_header(input int src, input int dst,
                                                                  input int len);
    logic [flit_pkg::FLIT_WIDTH-1:0] hdr;
    hdr = '0;
    hdr[flit_pkg::LEN_LSB +: flit_pkg::LEN_WIDTH] = len;
    hdr[flit_pkg::DEST_X_LSB +: noc_pkg::COORD_WIDTH] = dst % noc_pkg::NOC_DIM_X;
    hdr[flit_pkg::DEST_Y_LSB +: noc_pkg::COORD_WIDTH] = dst / noc_pkg::NOC_DIM_X;
    hdr[flit_pkg::SRC_LSB +: 8] = src;
    return hdr;
  endfunction

  // every out_tx_o seen at the falling edge is one flit taken by the pe
  always @(negedge clock) begin
    if (rst_n_i) begin
      for (int n = 0; n < noc_pkg::NODE_COUNT; n++) begin
        if (out_tx_o[n]) begin
          rx_q[n].push_back(out_data_o[n]);
          rx_count++;
        end
      end
    end
  end

  task automatic send_packet(input int src, input int dst, input int len);
    logic [flit_pkg::FLIT_WIDTH-1:0] flits [$];
    int                              idx;
    flits.push_back(make_header(src, dst, len));
    for (int i = 0; i < len; i++) begin
      flits.push_back($urandom());
    end
    foreach (flits[i]) begin
      sent_q[src * noc_pkg::NODE_COUNT + dst].push_back(flits[i]);
    end
    idx = 0;
    // one flit per cycle while the local input has room
    while (idx < flits.size()) begin
      @(posedge clock);
      #2;
      if (in_credit_o[src]) begin
        in_tx_i[src]   = 1'b1;
        in_data_i[src] = flits[idx];
        idx++;
      end else begin
        in_tx_i[src] = 1'b0;
      end
    end
    @(posedge clock);
    #2;
    in_tx_i[src] = 1'b0;
  endtask

  task automatic send_row(input int src);
    for (int d = 0; d < noc_pkg::NODE_COUNT; d++) begin
      send_packet(src, d, ALL_PAIRS_LEN);
    end
  endtask

  task automatic start_test(input string name);
    @(posedge clock);
    #2;
    // nothing may show up between tests
    for (int n = 0; n < noc_pkg::NODE_COUNT; n++) begin
      check_value({name, " stray flits"}, 0, rx_q[n].size());
    end
    rx_count = 0;
  endtask

  task automatic wait_flits(input int count);
    while (rx_count < count) begin
      @(posedge clock);
    end
  endtask

  // split each out port stream into whole packets and match them to what was sent
  task automatic check_packets(input string name);
    logic [flit_pkg::FLIT_WIDTH-1:0] hdr;
    int                              src;
    int                              len;
    int                              key;
    for (int n = 0; n < noc_pkg::NODE_COUNT; n++) begin
      while (rx_q[n].size() > 0) begin
        hdr = rx_q[n].pop_front();
        check_value({name, " destination"}, n,
                    hdr[flit_pkg::DEST_X_LSB +: noc_pkg::COORD_WIDTH]
                    + hdr[flit_pkg::DEST_Y_LSB +: noc_pkg::COORD_WIDTH] * noc_pkg::NOC_DIM_X);
        src = hdr[flit_pkg::SRC_LSB +: 8];
        len = hdr[flit_pkg::LEN_LSB +: flit_pkg::LEN_WIDTH];
        if (src >= noc_pkg::NODE_COUNT) begin
          stop_run($sformatf("%s: header at node %0d names an unknown source", name, n));
        end
        key = src * noc_pkg::NODE_COUNT + n;
        if (sent_q[key].size() != len + 1 || rx_q[n].size() < len) begin
          stop_run($sformatf("%s: node %0d got a packet that was not sent whole", name, n));
        end
        check_value({name, " header"}, sent_q[key].pop_front(), hdr);
        for (int i = 0; i < len; i++) begin
          check_value({name, " payload"}, sent_q[key].pop_front(), rx_q[n].pop_front());
        end
      end
    end
    for (int k = 0; k < noc_pkg::NODE_COUNT * noc_pkg::NODE_COUNT; k++) begin
      if (sent_q[k].size() != 0) begin
        stop_run($sformatf("%s: packet from node %0d to node %0d never arrived", name,
                           k / noc_pkg::NODE_COUNT, k % noc_pkg::NODE_COUNT));
      end
    end
  endtask

  task automatic reset_state_test();
    @(negedge clock);
    check_value("reset_state out_tx_o", '0, out_tx_o);
    check_value("reset_state in_credit_o", {noc_pkg::NODE_COUNT{1'b1}}, in_credit_o);
  endtask

  task automatic all_pairs_test();
    start_test("all_pairs");
    fork
      send_row(0);
      send_row(1);
      send_row(2);
      send_row(3);
    join
    wait_flits(noc_pkg::NODE_COUNT * noc_pkg::NODE_COUNT * (ALL_PAIRS_LEN + 1));
    check_packets("all_pairs");
  endtask

  // node 0 enters router 1 from the west and node 3 from the north
  task automatic contention_test();
    start_test("contention");
    fork
      send_packet(0, 1, CONTENTION_LEN);
      send_packet(3, 1, CONTENTION_LEN);
    join
    wait_flits(2 * (CONTENTION_LEN + 1));
    check_packets("contention");
  endtask

  task automatic backpressure_test();
    int waited;
    start_test("backpressure");
    out_credit_i[3] = 1'b0;
    fork
      send_packet(0, 3, BP_LEN);
      begin
        waited = 0;
        while (in_credit_o[0] && waited < BP_WAIT) begin
          @(negedge clock);
          waited++;
        end
        check_value("backpressure source credit", 0, in_credit_o[0]);
        repeat (8) @(posedge clock);
        check_value("backpressure held flits", 0, rx_q[3].size());
        #2;
        out_credit_i[3] = 1'b1;
      end
    join
    wait_flits(BP_LEN + 1);
    check_packets("backpressure");
  endtask

  task automatic crossing_test();
    start_test("crossing");
    fork
      send_packet(0, 3, CROSS_LEN);
      send_packet(3, 0, CROSS_LEN);
      send_packet(1, 2, CROSS_LEN);
      send_packet(2, 1, CROSS_LEN);
    join
    wait_flits(noc_pkg::NODE_COUNT * (CROSS_LEN + 1));
    check_packets("crossing");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    stop_run("timeout: the tests did not finish in the expected number of cycles");
  end

  initial begin
    wait (manycore_mesh_top_inst.manycore_mesh_assert_inst.failures != 0);
    stop_run("a concurrent assertion on the mesh failed");
  end

  initial begin
    void'($urandom(32'h0466_a516));
    rst_n_i      = 1'b0;
    in_tx_i      = '0;
    in_data_i    = '0;
    out_credit_i = '1;
    rx_count     = 0;
    repeat (5) @(posedge clock);
    #2;
    rst_n_i = 1'b1;
    reset_state_test();
    all_pairs_test();
    contention_test();
    backpressure_test();
    crossing_test();
    if (manycore_mesh_top_inst.manycore_mesh_assert_inst.failures == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run("a concurrent assertion on the mesh failed");
    end
  end

endmodule : manycore_mesh_tb
